// File: Makefile
VERILATOR ?= verilator
TOP       := tb_commit_trace
FILELIST  := src.f
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Test completed successfully
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src.f
src/trace_pkg.sv
src/trace_port_if.sv
src/retire_counters.sv
src/pc_queue.sv
src/drain_arbiter.sv
src/commit_trace.sv
verif/tb_commit_trace.sv

// File: src/commit_trace.sv
`default_nettype none

module commit_trace #(
  parameter  int unsigned NrCommitPorts = 2,
  parameter  int unsigned QueueDepth    = 4,
  localparam int unsigned IdxWidth      = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [NrCommitPorts-1:0]                            commit_ack_i,
  input  logic [NrCommitPorts-1:0]                            commit_ex_i,
  input  logic [NrCommitPorts-1:0][trace_pkg::PcWidth-1:0]    commit_pc_i,
  input  logic [NrCommitPorts-1:0][trace_pkg::CauseWidth-1:0] commit_cause_i,
  output logic                                                trace_valid_o,
  output logic [trace_pkg::PcWidth-1:0]                       trace_pc_o,
  output logic [trace_pkg::StampWidth-1:0]                    trace_stamp_o,
  output logic [IdxWidth-1:0]                                 trace_port_o,
  output logic [trace_pkg::StampWidth-1:0]                    illegal_o,
  output logic [trace_pkg::StampWidth-1:0]                    exceptions_o,
  output logic [trace_pkg::StampWidth-1:0]                    drops_o
);

  logic [trace_pkg::StampWidth-1:0]            cycle;
  logic [NrCommitPorts-1:0]                    push;
  logic [NrCommitPorts-1:0]                    full;
  logic [NrCommitPorts-1:0]                    pop;
  trace_pkg::trace_entry_t [NrCommitPorts-1:0] entry;

  trace_port_if port_if [NrCommitPorts-1:0] ();

  // only clean commits are traced
  assign push = commit_ack_i & ~commit_ex_i;

  // -------------------------------------------------------------------------
  // cycle stamp and retire statistics
  // -------------------------------------------------------------------------
  retire_counters #(
    .NrCommitPorts  ( NrCommitPorts  )
  ) retire_counters_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_ack_i   ( commit_ack_i   ),
    .commit_ex_i    ( commit_ex_i    ),
    .commit_cause_i ( commit_cause_i ),
    .push_i         ( push           ),
    .full_i         ( full           ),
    .pop_i          ( pop            ),
    .cycle_o        ( cycle          ),
    .illegal_o      ( illegal_o      ),
    .exceptions_o   ( exceptions_o   ),
    .drops_o        ( drops_o        )
  );

  // -------------------------------------------------------------------------
  // one pc queue per commit port
  // -------------------------------------------------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_queue
    assign entry[i].pc    = commit_pc_i[i];
    assign entry[i].stamp = cycle;

    pc_queue #(
      .QueueDepth ( QueueDepth  )
    ) pc_queue_inst (
      .clk_i      ( clk_i       ),
      .rst_ni     ( rst_ni      ),
      .push_i     ( push[i]     ),
      .entry_i    ( entry[i]    ),
      .port_o     ( port_if[i]  )
    );

    // status taps for the drop counter
    assign full[i] = port_if[i].full;
    assign pop[i]  = port_if[i].gnt;
  end

  // -------------------------------------------------------------------------
  // drain to the trace output
  // -------------------------------------------------------------------------
  drain_arbiter #(
    .NrCommitPorts ( NrCommitPorts )
  ) drain_arbiter_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .ports         ( port_if       ),
    .trace_valid_o ( trace_valid_o ),
    .trace_pc_o    ( trace_pc_o    ),
    .trace_stamp_o ( trace_stamp_o ),
    .trace_port_o  ( trace_port_o  )
  );

endmodule

`default_nettype wire

// File: src/drain_arbiter.sv
`default_nettype none

module drain_arbiter #(
  parameter  int unsigned NrCommitPorts = 2,
  localparam int unsigned IdxWidth      = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  trace_port_if.arb                        ports [NrCommitPorts-1:0],
  output logic                             trace_valid_o,
  output logic [trace_pkg::PcWidth-1:0]    trace_pc_o,
  output logic [trace_pkg::StampWidth-1:0] trace_stamp_o,
  output logic [IdxWidth-1:0]              trace_port_o
);

  logic [NrCommitPorts-1:0]                    req;
  trace_pkg::trace_entry_t [NrCommitPorts-1:0] head;
  logic [IdxWidth-1:0]                         ptr_q;
  logic [IdxWidth-1:0]                         ptr_d;
  logic [IdxWidth-1:0]                         win_idx;
  logic                                        win_valid;

  // per-port request, head and grant
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_port_tap
    assign req[i]        = ports[i].req;
    assign head[i]       = ports[i].head;
    assign ports[i].gnt  = win_valid && (win_idx == IdxWidth'(i));
  end

  // -------------------------------------------------------------------------
  // round-robin pick of the first requester at or after the pointer
  // -------------------------------------------------------------------------
  always_comb begin
    int unsigned idx;
    win_valid = 1'b0;
    win_idx   = '0;
    for (int unsigned k = 0; k < NrCommitPorts; k++) begin
      idx = ptr_q + k;
      if (idx >= NrCommitPorts) begin
        idx = idx - NrCommitPorts;
      end
      if (!win_valid && req[idx]) begin
        win_valid = 1'b1;
        win_idx   = IdxWidth'(idx);
      end
    end
  end

  // priority restarts just past the winner
  assign ptr_d = (win_idx == IdxWidth'(NrCommitPorts - 1)) ? '0 : win_idx + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q         <= '0;
      trace_valid_o <= 1'b0;
    end else begin
      trace_valid_o <= win_valid;
      if (win_valid) begin
        ptr_q <= ptr_d;
      end
    end
  end

  // payload of the granted entry
  always_ff @(posedge clk_i) begin
    if (win_valid) begin
      trace_pc_o    <= head[win_idx].pc;
      trace_stamp_o <= head[win_idx].stamp;
      trace_port_o  <= win_idx;
    end
  end

endmodule

`default_nettype wire

// File: src/pc_queue.sv
`default_nettype none

module pc_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  trace_pkg::trace_entry_t entry_i,
  trace_port_if.queue             port_o
);

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  trace_pkg::trace_entry_t mem_q [QueueDepth];
  logic [PtrWidth-1:0]     rd_ptr_q;
  logic [PtrWidth-1:0]     wr_ptr_q;
  logic [CntWidth-1:0]     cnt_q;
  logic                    full;
  logic                    pop;
  logic                    push_ok;

  // wrap at the depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    logic [PtrWidth-1:0] nxt;
    if (ptr == PtrWidth'(QueueDepth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full    = (cnt_q == CntWidth'(QueueDepth));
  assign pop     = port_o.gnt;
  // full queue still takes a push when it is popped in the same cycle
  assign push_ok = push_i && (!full || pop);

  assign port_o.req  = (cnt_q != '0);
  assign port_o.head = mem_q[rd_ptr_q];
  assign port_o.full = full;

  // -------------------------------------------------------------------------
  // pointers and occupancy
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_ok, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

`default_nettype wire

// File: src/retire_counters.sv
`default_nettype none

module retire_counters #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [NrCommitPorts-1:0]                            commit_ack_i,
  input  logic [NrCommitPorts-1:0]                            commit_ex_i,
  input  logic [NrCommitPorts-1:0][trace_pkg::CauseWidth-1:0] commit_cause_i,
  input  logic [NrCommitPorts-1:0]                            push_i,
  input  logic [NrCommitPorts-1:0]                            full_i,
  input  logic [NrCommitPorts-1:0]                            pop_i,
  output logic [trace_pkg::StampWidth-1:0]                    cycle_o,
  output logic [trace_pkg::StampWidth-1:0]                    illegal_o,
  output logic [trace_pkg::StampWidth-1:0]                    exceptions_o,
  output logic [trace_pkg::StampWidth-1:0]                    drops_o
);

  logic [trace_pkg::StampWidth-1:0] illegal_inc;
  logic [trace_pkg::StampWidth-1:0] ex_inc;
  logic [trace_pkg::StampWidth-1:0] drop_inc;

  // events of this cycle, summed over all commit ports
  always_comb begin
    illegal_inc = '0;
    ex_inc      = '0;
    drop_inc    = '0;
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      if (commit_ack_i[i] && commit_ex_i[i]) begin
        if (commit_cause_i[i] == trace_pkg::CauseIllegal) begin
          illegal_inc = illegal_inc + 1'b1;
        end else begin
          ex_inc = ex_inc + 1'b1;
        end
      end
      // a pop in the same cycle frees the slot
      if (push_i[i] && full_i[i] && !pop_i[i]) begin
        drop_inc = drop_inc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_o      <= '0;
      illegal_o    <= '0;
      exceptions_o <= '0;
      drops_o      <= '0;
    end else begin
      cycle_o      <= cycle_o + 1'b1;
      illegal_o    <= illegal_o + illegal_inc;
      exceptions_o <= exceptions_o + ex_inc;
      drops_o      <= drops_o + drop_inc;
    end
  end

endmodule

`default_nettype wire

// File: src/trace_pkg.sv
`default_nettype none

package trace_pkg;

  // -------------------------------------------------------------------------
  // widths
  // -------------------------------------------------------------------------
  // program counter of a committed instruction
  localparam int unsigned PcWidth    = 64;
  // cycle stamp and all retire counters
  localparam int unsigned StampWidth = 32;
  localparam int unsigned CauseWidth = 5;

  // -------------------------------------------------------------------------
  // exception causes
  // -------------------------------------------------------------------------
  // illegal instruction
  localparam logic [CauseWidth-1:0] CauseIllegal = 5'd2;

  // -------------------------------------------------------------------------
  // queued trace record
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic [PcWidth-1:0]    pc;
    logic [StampWidth-1:0] stamp;
  } trace_entry_t;

endpackage

`default_nettype wire

// File: src/trace_port_if.sv
`default_nettype none

interface trace_port_if;
  // queue holds at least one entry
  logic                    req;
  // oldest entry in the queue
  trace_pkg::trace_entry_t head;
  // pop strobe that only rises while req is high
  logic                    gnt;
  logic                    full;

  modport queue (
    output req,
    output head,
    output full,
    input  gnt
  );

  modport arb (
    input  req,
    input  head,
    input  full,
    output gnt
  );

endinterface

`default_nettype wire

// File: verif/tb_commit_trace.sv
`default_nettype none

module tb_commit_trace;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NrPorts    = 2;
  localparam int unsigned Depth      = 4;
  localparam int unsigned RandomRows = 200;
  localparam logic [4:0]  IllegalCause = 5'd2;

  typedef struct {
    logic [NrPorts-1:0]        ack;
    logic [NrPorts-1:0]        ex;
    logic [NrPorts-1:0][63:0]  pc;
    logic [NrPorts-1:0][4:0]   cause;
    string                     name;
  } row_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic [NrPorts-1:0]        commit_ack;
  logic [NrPorts-1:0]        commit_ex;
  logic [NrPorts-1:0][63:0]  commit_pc;
  logic [NrPorts-1:0][4:0]   commit_cause;
  logic                      trace_valid;
  logic [63:0]               trace_pc;
  logic [31:0]               trace_stamp;
  logic [0:0]                trace_port;
  logic [31:0]               illegal;
  logic [31:0]               exceptions;
  logic [31:0]               drops;

  // reference model state
  trace_pkg::trace_entry_t mq [NrPorts][Depth];
  int                      mcnt [NrPorts];
  int                      mptr;
  logic [31:0]             medge;
  logic [31:0]             m_illegal;
  logic [31:0]             m_exceptions;
  logic [31:0]             m_drops;
  logic                    exp_valid;
  trace_pkg::trace_entry_t exp_entry;
  logic [0:0]              exp_port;

  row_t table_q [$];
  int   seed;
  int   errors;
  int   traced;
  int   clean_commits;
  int   cycle_cnt;
  int   timeout_limit = 100000;

  commit_trace commit_trace_inst (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .commit_ack_i   ( commit_ack   ),
    .commit_ex_i    ( commit_ex    ),
    .commit_pc_i    ( commit_pc    ),
    .commit_cause_i ( commit_cause ),
    .trace_valid_o  ( trace_valid  ),
    .trace_pc_o     ( trace_pc     ),
    .trace_stamp_o  ( trace_stamp  ),
    .trace_port_o   ( trace_port   ),
    .illegal_o      ( illegal      ),
    .exceptions_o   ( exceptions   ),
    .drops_o        ( drops        )
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // reference model stepped once per rising edge
  // --------------------------------------------------------------------------
  task automatic model_step();
    int win;
    int idx;
    win = -1;
    for (int k = 0; k < NrPorts; k++) begin
      idx = (mptr + k) % NrPorts;
      if (win < 0 && mcnt[idx] != 0) begin
        win = idx;
      end
    end
    exp_valid = (win >= 0);
    if (exp_valid) begin
      exp_entry = mq[win][0];
      exp_port  = 1'(win);
      for (int j = 0; j < Depth - 1; j++) begin
        mq[win][j] = mq[win][j+1];
      end
      mcnt[win] = mcnt[win] - 1;
      mptr = (win + 1) % NrPorts;
    end
    // pushes see the queue after this edge's pop
    for (int p = 0; p < NrPorts; p++) begin
      if (commit_ack[p] && commit_ex[p]) begin
        if (commit_cause[p] == IllegalCause) begin
          m_illegal = m_illegal + 1;
        end else begin
          m_exceptions = m_exceptions + 1;
        end
      end else if (commit_ack[p]) begin
        clean_commits++;
        if (mcnt[p] == Depth) begin
          m_drops = m_drops + 1;
        end else begin
          mq[p][mcnt[p]].pc    = commit_pc[p];
          mq[p][mcnt[p]].stamp = medge;
          mcnt[p] = mcnt[p] + 1;
        end
      end
    end
    medge = medge + 1;
  endtask

  task automatic check_outputs(input string name);
    if (trace_valid === 1'b1) begin
      traced++;
    end
    if (trace_valid !== exp_valid) begin
      errors++;
      $display("MISMATCH %s valid expected %0b actual %0b", name, exp_valid, trace_valid);
    end else if (exp_valid) begin
      if (trace_pc !== exp_entry.pc) begin
        errors++;
        $display("MISMATCH %s pc expected %h actual %h", name, exp_entry.pc, trace_pc);
      end
      if (trace_stamp !== exp_entry.stamp) begin
        errors++;
        $display("MISMATCH %s stamp expected %0d actual %0d", name, exp_entry.stamp,
                 trace_stamp);
      end
      if (trace_port !== exp_port) begin
        errors++;
        $display("MISMATCH %s port expected %0d actual %0d", name, exp_port, trace_port);
      end
    end
    if (illegal !== m_illegal) begin
      errors++;
      $display("MISMATCH %s illegal expected %0d actual %0d", name, m_illegal, illegal);
    end
    if (exceptions !== m_exceptions) begin
      errors++;
      $display("MISMATCH %s exceptions expected %0d actual %0d", name, m_exceptions,
               exceptions);
    end
    if (drops !== m_drops) begin
      errors++;
      $display("MISMATCH %s drops expected %0d actual %0d", name, m_drops, drops);
    end
  endtask

  // drive on the falling edge, check at the next one
  task automatic apply_row(input row_t row);
    commit_ack   = row.ack;
    commit_ex    = row.ex;
    commit_pc    = row.pc;
    commit_cause = row.cause;
    @(negedge clk_i);
    model_step();
    check_outputs(row.name);
  endtask

  task automatic add_row(input logic [1:0] ack, input logic [1:0] ex, input logic [63:0] pc0,
                         input logic [63:0] pc1, input logic [4:0] c0, input logic [4:0] c1,
                         input string name);
    row_t row;
    row.ack   = ack;
    row.ex    = ex;
    row.pc    = {pc1, pc0};
    row.cause = {c1, c0};
    row.name  = name;
    table_q.push_back(row);
  endtask

  task automatic build_table();
    add_row(2'b01, 2'b00, 64'h8000_0000, 64'h0, 5'd0, 5'd0, "single_p0");
    for (int i = 0; i < 3; i++) begin
      add_row(2'b00, 2'b00, 64'h0, 64'h0, 5'd0, 5'd0, "single_idle");
    end
    for (int i = 0; i < 3; i++) begin
      add_row(2'b11, 2'b00, 64'h8000_0100 + 64'(i * 4), 64'h9000_0100 + 64'(i * 4),
              5'd0, 5'd0, "dual");
    end
    for (int i = 0; i < 4; i++) begin
      add_row(2'b00, 2'b00, 64'h0, 64'h0, 5'd0, 5'd0, "dual_idle");
    end
    add_row(2'b01, 2'b01, 64'h8000_0200, 64'h0, 5'd2, 5'd0, "illegal_p0");
    add_row(2'b10, 2'b10, 64'h0, 64'h9000_0200, 5'd0, 5'd7, "other_ex_p1");
    add_row(2'b11, 2'b01, 64'h8000_0204, 64'h9000_0204, 5'd2, 5'd0, "illegal_mix");
    add_row(2'b11, 2'b11, 64'h8000_0208, 64'h9000_0208, 5'd13, 5'd2, "both_ex");
    add_row(2'b00, 2'b00, 64'h0, 64'h0, 5'd0, 5'd0, "ex_idle");
    // two pushes per cycle against one pop fills both queues
    for (int i = 0; i < 10; i++) begin
      add_row(2'b11, 2'b00, 64'hA000_0000 + 64'(i * 4), 64'hB000_0000 + 64'(i * 4),
              5'd0, 5'd0, "overflow");
    end
  endtask

  function automatic row_t random_row();
    row_t        row;
    logic [31:0] r;
    r = $random(seed);
    row.ack      = r[1:0];
    row.ex       = r[3:2] & r[5:4];
    row.cause[0] = r[6] ? IllegalCause : r[11:7];
    row.cause[1] = r[12] ? IllegalCause : r[17:13];
    row.pc[0]    = {$random(seed), $random(seed)};
    row.pc[1]    = {$random(seed), $random(seed)};
    row.name     = "random";
    return row;
  endfunction

  function automatic int queued_entries();
    int sum;
    sum = 0;
    for (int p = 0; p < NrPorts; p++) begin
      sum = sum + mcnt[p];
    end
    return sum;
  endfunction

  task automatic drain_queues(input string name);
    row_t idle;
    idle.ack   = '0;
    idle.ex    = '0;
    idle.pc    = '0;
    idle.cause = '0;
    idle.name  = name;
    while (queued_entries() != 0) begin
      apply_row(idle);
    end
  endtask

  task automatic check_balance(input string name);
    int sum;
    sum = traced + int'(drops);
    if (sum != clean_commits) begin
      errors++;
      $display("MISMATCH %s balance expected %0d actual %0d", name, clean_commits, sum);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    row_t row;
    seed          = 32'h50bc6eea;
    errors        = 0;
    traced        = 0;
    clean_commits = 0;
    mptr          = 0;
    medge         = '0;
    m_illegal     = '0;
    m_exceptions  = '0;
    m_drops       = '0;
    exp_valid     = 1'b0;
    for (int p = 0; p < NrPorts; p++) begin
      mcnt[p] = 0;
    end
    rst_ni       = 1'b0;
    commit_ack   = '0;
    commit_ex    = '0;
    commit_pc    = '0;
    commit_cause = '0;
    build_table();
    timeout_limit = table_q.size() + RandomRows + 50;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (table_q[i]) begin
      apply_row(table_q[i]);
    end
    drain_queues("table_drain");
    check_balance("table");
    for (int i = 0; i < RandomRows; i++) begin
      row = random_row();
      apply_row(row);
    end
    drain_queues("random_drain");
    check_balance("random");
    $display("errors %0d, traced %0d, illegal %0d, exceptions %0d, drops %0d",
             errors, traced, illegal, exceptions, drops);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // cycle limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_limit);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
